// File: vlog.f
+incdir+.
ddr_io_pkg.sv
afi_c2p_stage.sv
dqs_group_lane.sv
rdata_valid_combiner.sv
ddr_io_pads.sv
tb_ddr_io_pads.sv

// File: tb_ddr_io_model.svh
`ifndef TB_DDR_IO_MODEL_SVH
`define TB_DDR_IO_MODEL_SVH

// Reference model of the pad block, written from the slicing and timing rules
// The AFI buses are ordered by slot first and group second
// The pad outputs are ordered by group first and slot second

// Data field of slot s for group g moves from index s*groups+g to index g*slots+s
function automatic afi_data_t expected_dq_slots(input afi_data_t afi_dq);
	afi_data_t result;
	int src_field;
	int dst_field;
	result = '0;
	for (int g = 0; g < num_dqs_groups; g++) begin
		for (int s = 0; s < num_slots; s++) begin
			src_field = s * num_dqs_groups + g;
			dst_field = g * num_slots + s;
			result[dst_field*dq_per_group +: dq_per_group] =
				afi_dq[src_field*dq_per_group +: dq_per_group];
		end
	end
	return result;
endfunction

// Mask bits follow the same rule with one bit per field
function automatic afi_mask_t expected_dm_slots(input afi_mask_t afi_mask);
	afi_mask_t result;
	result = '0;
	for (int g = 0; g < num_dqs_groups; g++) begin
		for (int s = 0; s < num_slots; s++) begin
			result[g*num_slots+s] = afi_mask[s*num_dqs_groups+g];
		end
	end
	return result;
endfunction

// Enable bit p*groups+g lands on phase p of group g
function automatic afi_wren_t expected_dq_oe(input afi_wren_t afi_wren);
	afi_wren_t result;
	result = '0;
	for (int g = 0; g < num_dqs_groups; g++) begin
		for (int p = 0; p < afi_rate_ratio; p++) begin
			result[g*afi_rate_ratio+p] = afi_wren[p*num_dqs_groups+g];
		end
	end
	return result;
endfunction

// A latency of zero acts like one
function automatic int effective_latency(input read_latency_t latency);
	if (latency == 0) begin
		return 1;
	end
	return int'(latency);
endfunction

// Edge at which the valid is first seen for a read enable sampled at edge k
// The extra VFIFO shift and the combiner register each add one cycle
function automatic int expected_valid_cycle(input int sample_edge, input read_latency_t latency);
	return sample_edge + effective_latency(latency) + extra_vfifo_shift + 1;
endfunction

`endif

// File: tb_ddr_io_pads.sv
`timescale 1ns/1ps

module tb_ddr_io_pads;
	import ddr_io_pkg::*;

	`include "tb_ddr_io_model.svh"

	localparam int reset_cycles = 4;
	localparam int n_random_writes = 200;
	localparam int n_pattern = 64;

	// Long enough to flush the whole read delay line and the pipeline behind it
	localparam int drain_cycles = 40;

	localparam int cycle_limit = reset_cycles + 2 + n_random_writes + 2 * afi_wren_width
		+ drain_cycles + 4 * (drain_cycles + 2) + 2 * (n_pattern + drain_cycles + 2) + 50;

	logic pll_afi_clk;
	logic reset_n_afi_clk;
	afi_data_t phy_ddio_dq;
	afi_mask_t phy_ddio_wrdata_mask;
	afi_wren_t phy_ddio_wrdata_en;
	rate_vec_t afi_rdata_en_full;
	read_latency_t seq_read_latency_counter;
	afi_data_t mem_dq_slots;
	afi_mask_t mem_dm_slots;
	afi_wren_t mem_dq_oe;
	rate_vec_t afi_rdata_valid;

	int write_errors = 0;
	int valid_errors = 0;
	int other_errors = 0;
	int cycle_count = 0;
	int edge_idx = 0;

	// Expected write outputs, oldest first, and the edges that owe a read valid
	afi_data_t exp_dq_q[$];
	afi_mask_t exp_dm_q[$];
	afi_wren_t exp_oe_q[$];
	bit valid_due[int];

	afi_data_t want_dq;
	afi_mask_t want_dm;
	afi_wren_t want_oe;
	rate_vec_t want_valid;

	ddr_io_pads ddr_io_pads_inst (
		.pll_afi_clk              (pll_afi_clk),
		.reset_n_afi_clk          (reset_n_afi_clk),
		.phy_ddio_dq              (phy_ddio_dq),
		.phy_ddio_wrdata_mask     (phy_ddio_wrdata_mask),
		.phy_ddio_wrdata_en       (phy_ddio_wrdata_en),
		.afi_rdata_en_full        (afi_rdata_en_full),
		.seq_read_latency_counter (seq_read_latency_counter),
		.mem_dq_slots             (mem_dq_slots),
		.mem_dm_slots             (mem_dm_slots),
		.mem_dq_oe                (mem_dq_oe),
		.afi_rdata_valid          (afi_rdata_valid)
	);

	initial begin
		pll_afi_clk = 1'b0;
		forever #50 pll_afi_clk = ~pll_afi_clk;
	end

	initial begin
		while (cycle_count < cycle_limit) begin
			@(posedge pll_afi_clk);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
		print_error_counts();
		$display("CHECKS FAILED");
		$finish;
	end

	// Registered outputs are read before this edge updates them
	// so they still show the result of the previous edge
	always @(posedge pll_afi_clk) begin
		if (reset_n_afi_clk) begin
			if (exp_dq_q.size() == 2) begin
				want_dq = exp_dq_q.pop_front();
				want_dm = exp_dm_q.pop_front();
				want_oe = exp_oe_q.pop_front();
				assert (mem_dq_slots === want_dq) else begin
					write_errors++;
					$display("FAILED at %0t: mem_dq_slots is %h, expected %h",
						$time, mem_dq_slots, want_dq);
				end
				assert (mem_dm_slots === want_dm) else begin
					write_errors++;
					$display("FAILED at %0t: mem_dm_slots is %b, expected %b",
						$time, mem_dm_slots, want_dm);
				end
				assert (mem_dq_oe === want_oe) else begin
					write_errors++;
					$display("FAILED at %0t: mem_dq_oe is %b, expected %b",
						$time, mem_dq_oe, want_oe);
				end
			end
			want_valid = '0;
			if (valid_due.exists(edge_idx)) begin
				want_valid = '1;
				valid_due.delete(edge_idx);
			end
			assert (afi_rdata_valid === want_valid) else begin
				valid_errors++;
				$display("FAILED at %0t: afi_rdata_valid is %b, expected %b (L = %0d)",
					$time, afi_rdata_valid, want_valid, seq_read_latency_counter);
			end
			exp_dq_q.push_back(expected_dq_slots(phy_ddio_dq));
			exp_dm_q.push_back(expected_dm_slots(phy_ddio_wrdata_mask));
			exp_oe_q.push_back(expected_dq_oe(phy_ddio_wrdata_en));
			if (afi_rdata_en_full[0]) begin
				valid_due[expected_valid_cycle(edge_idx, seq_read_latency_counter)] = 1'b1;
			end
		end
		edge_idx++;
	end

	task automatic print_error_counts();
		$display("Error counts: write path %0d, read valid %0d, other %0d",
			write_errors, valid_errors, other_errors);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge pll_afi_clk);
			phy_ddio_dq = '0;
			phy_ddio_wrdata_mask = '0;
			phy_ddio_wrdata_en = '0;
			afi_rdata_en_full = '0;
		end
	endtask

	task automatic check_reset_state();
		assert (mem_dq_slots === '0 && mem_dm_slots === '0) else begin
			write_errors++;
			$display("FAILED at %0t: data or mask output not cleared by reset", $time);
		end
		assert (mem_dq_oe === '0) else begin
			write_errors++;
			$display("FAILED at %0t: mem_dq_oe is %b after reset", $time, mem_dq_oe);
		end
		assert (afi_rdata_valid === '0) else begin
			valid_errors++;
			$display("FAILED at %0t: afi_rdata_valid is %b after reset", $time, afi_rdata_valid);
		end
	endtask

	// A fresh value on every bus in every cycle
	task automatic drive_random_writes(input int n);
		repeat (n) begin
			@(negedge pll_afi_clk);
			phy_ddio_dq = {$urandom, $urandom};
			phy_ddio_wrdata_mask = afi_mask_t'($urandom);
			phy_ddio_wrdata_en = afi_wren_t'($urandom);
		end
	endtask

	task automatic walk_write_enable();
		for (int i = 0; i < afi_wren_width; i++) begin
			@(negedge pll_afi_clk);
			phy_ddio_dq = {$urandom, $urandom};
			phy_ddio_wrdata_mask = afi_mask_t'($urandom);
			phy_ddio_wrdata_en = afi_wren_t'(1) << i;
			@(negedge pll_afi_clk);
			phy_ddio_wrdata_en = '0;
		end
	endtask

	task automatic send_read_pulse(input read_latency_t latency);
		@(negedge pll_afi_clk);
		seq_read_latency_counter = latency;
		afi_rdata_en_full = '0;
		@(negedge pll_afi_clk);
		afi_rdata_en_full = '1;
		idle_cycles(drain_cycles);
	endtask

	// Back-to-back mode starts with a long burst, then leaves gaps every third cycle
	// Random mode drives phase 1 on its own, and only phase 0 may reach the valid
	task automatic send_read_pattern(input read_latency_t latency, input bit random_mode);
		bit en;
		@(negedge pll_afi_clk);
		seq_read_latency_counter = latency;
		afi_rdata_en_full = '0;
		for (int i = 0; i < n_pattern; i++) begin
			@(negedge pll_afi_clk);
			if (random_mode) begin
				afi_rdata_en_full = rate_vec_t'($urandom);
			end else begin
				en = (i < 16) || (i % 3 != 0);
				afi_rdata_en_full = {afi_rate_ratio{en}};
			end
		end
		idle_cycles(drain_cycles + 1);
	endtask

	initial begin
		void'($urandom(13));
		reset_n_afi_clk = 1'b0;
		phy_ddio_dq = '0;
		phy_ddio_wrdata_mask = '0;
		phy_ddio_wrdata_en = '0;
		afi_rdata_en_full = '0;
		seq_read_latency_counter = '0;
		repeat (reset_cycles) @(posedge pll_afi_clk);
		@(negedge pll_afi_clk);
		reset_n_afi_clk = 1'b1;
		// No clock edge has passed since release, so every output still shows its reset value
		check_reset_state();

		drive_random_writes(n_random_writes);
		walk_write_enable();
		idle_cycles(drain_cycles);

		send_read_pulse(read_latency_t'(1));
		send_read_pulse(read_latency_t'(5));
		send_read_pulse(read_latency_t'(31));
		send_read_pulse(read_latency_t'(0));

		send_read_pattern(read_latency_t'(7), 1'b0);
		send_read_pattern(read_latency_t'(12), 1'b1);

		assert (valid_due.num() == 0) else begin
			other_errors++;
			$display("Expected read valid pulses never arrived: %0d still pending",
				valid_due.num());
		end

		print_error_counts();
		if (write_errors + valid_errors + other_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: ddr_io_pads.sv
`timescale 1ns/1ps

module ddr_io_pads (
	input  logic                       pll_afi_clk,
	input  logic                       reset_n_afi_clk,
	input  ddr_io_pkg::afi_data_t      phy_ddio_dq,
	input  ddr_io_pkg::afi_mask_t      phy_ddio_wrdata_mask,
	input  ddr_io_pkg::afi_wren_t      phy_ddio_wrdata_en,
	input  ddr_io_pkg::rate_vec_t      afi_rdata_en_full,
	input  ddr_io_pkg::read_latency_t  seq_read_latency_counter,
	output ddr_io_pkg::afi_data_t      mem_dq_slots,
	output ddr_io_pkg::afi_mask_t      mem_dm_slots,
	output ddr_io_pkg::afi_wren_t      mem_dq_oe,
	output ddr_io_pkg::rate_vec_t      afi_rdata_valid
);
	import ddr_io_pkg::*;

	// Registered AFI buses from the feeder
	afi_data_t c2p_dq;
	afi_mask_t c2p_mask;
	afi_wren_t c2p_wren;
	logic rdata_en_full_shifted;

	// One latency FIFO valid per group
	logic [num_dqs_groups-1:0] rdata_valid;

	afi_c2p_stage afi_c2p_stage_inst (
		.pll_afi_clk           (pll_afi_clk),
		.reset_n_afi_clk       (reset_n_afi_clk),
		.phy_ddio_dq           (phy_ddio_dq),
		.phy_ddio_wrdata_mask  (phy_ddio_wrdata_mask),
		.phy_ddio_wrdata_en    (phy_ddio_wrdata_en),
		.afi_rdata_en_full     (afi_rdata_en_full),
		.c2p_dq                (c2p_dq),
		.c2p_mask              (c2p_mask),
		.c2p_wren              (c2p_wren),
		.rdata_en_full_shifted (rdata_en_full_shifted)
	);

	// The AFI buses run slot by slot, with the groups interleaved inside each slot
	// Each lane gets its group's fields gathered into slot order
	for (genvar g = 0; g < num_dqs_groups; g++) begin : g_lane
		group_dq_t lane_dq;
		group_dm_t lane_dm;
		group_oe_t lane_oe;

		for (genvar s = 0; s < num_slots; s++) begin : g_slot
			assign lane_dq[s*dq_per_group +: dq_per_group] =
				c2p_dq[(s*num_dqs_groups+g)*dq_per_group +: dq_per_group];
			assign lane_dm[s] = c2p_mask[s*num_dqs_groups+g];
		end

		// Write enable bit p*groups+g steers phase p of group g only
		for (genvar p = 0; p < afi_rate_ratio; p++) begin : g_phase
			assign lane_oe[p] = c2p_wren[p*num_dqs_groups+g];
		end

		dqs_group_lane dqs_group_lane_inst (
			.pll_afi_clk     (pll_afi_clk),
			.reset_n_afi_clk (reset_n_afi_clk),
			.slot_dq         (lane_dq),
			.slot_dm         (lane_dm),
			.slot_oe         (lane_oe),
			.rdata_en_full   (rdata_en_full_shifted),
			.read_latency    (seq_read_latency_counter),
			.mem_dq          (mem_dq_slots[g*group_dq_width +: group_dq_width]),
			.mem_dm          (mem_dm_slots[g*num_slots +: num_slots]),
			.mem_oe          (mem_dq_oe[g*afi_rate_ratio +: afi_rate_ratio]),
			.rdata_valid     (rdata_valid[g])
		);
	end

	rdata_valid_combiner rdata_valid_combiner_inst (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.group_valid     (rdata_valid),
		.afi_rdata_valid (afi_rdata_valid)
	);

endmodule

// File: rdata_valid_combiner.sv
`timescale 1ns/1ps

module rdata_valid_combiner (
	input  logic                                  pll_afi_clk,
	input  logic                                  reset_n_afi_clk,
	input  logic [ddr_io_pkg::num_dqs_groups-1:0] group_valid,
	output ddr_io_pkg::rate_vec_t                 afi_rdata_valid
);
	import ddr_io_pkg::*;

	// Read data is only usable once every group has its word
	logic all_valid;

	assign all_valid = &group_valid;

	// Each rate phase sees the same valid
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			afi_rdata_valid <= '0;
		end else begin
			afi_rdata_valid <= {afi_rate_ratio{all_valid}};
		end
	end

endmodule

// File: dqs_group_lane.sv
`timescale 1ns/1ps

module dqs_group_lane (
	input  logic                       pll_afi_clk,
	input  logic                       reset_n_afi_clk,
	input  ddr_io_pkg::group_dq_t      slot_dq,
	input  ddr_io_pkg::group_dm_t      slot_dm,
	input  ddr_io_pkg::group_oe_t      slot_oe,
	input  logic                       rdata_en_full,
	input  ddr_io_pkg::read_latency_t  read_latency,
	output ddr_io_pkg::group_dq_t      mem_dq,
	output ddr_io_pkg::group_dm_t      mem_dm,
	output ddr_io_pkg::group_oe_t      mem_oe,
	output logic                       rdata_valid
);
	import ddr_io_pkg::*;

	// Read enable history, stage i holds the request from i+1 cycles ago
	logic [read_delay_depth-1:0] delay_q;

	// Index of the delay-line stage that matches the programmed latency
	read_latency_t tap_sel;

	// Output registers of the group
	// Slot 0 goes out first on the wire, so it stays in the low byte
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			mem_dq <= '0;
			mem_dm <= '0;
		end else begin
			mem_dq <= slot_dq;
			mem_dm <= slot_dm;
		end
	end

	// Output enable per rate phase
	// Phase 0 covers slots 0 and 1, phase 1 covers slots 2 and 3
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			mem_oe <= '0;
		end else begin
			mem_oe <= slot_oe;
		end
	end

	// Latency FIFO valid model
	// Every request moves one stage per cycle, so any number can be in flight
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			delay_q <= '0;
		end else begin
			delay_q <= {delay_q[read_delay_depth-2:0], rdata_en_full};
		end
	end

	// A latency of L reads stage L-1, and zero is treated like one
	always_comb begin
		if (read_latency == '0) begin
			tap_sel = '0;
		end else begin
			tap_sel = read_latency - read_latency_t'(1);
		end
	end

	// Stage select is a plain mux over flops, the combiner registers it
	assign rdata_valid = delay_q[tap_sel];

endmodule

// File: afi_c2p_stage.sv
`timescale 1ns/1ps

module afi_c2p_stage (
	input  logic                    pll_afi_clk,
	input  logic                    reset_n_afi_clk,
	input  ddr_io_pkg::afi_data_t   phy_ddio_dq,
	input  ddr_io_pkg::afi_mask_t   phy_ddio_wrdata_mask,
	input  ddr_io_pkg::afi_wren_t   phy_ddio_wrdata_en,
	input  ddr_io_pkg::rate_vec_t   afi_rdata_en_full,
	output ddr_io_pkg::afi_data_t   c2p_dq,
	output ddr_io_pkg::afi_mask_t   c2p_mask,
	output ddr_io_pkg::afi_wren_t   c2p_wren,
	output logic                    rdata_en_full_shifted
);
	import ddr_io_pkg::*;

	// Core to periphery register for the whole write bus
	// The lanes then see a path that starts at a flop and not in core logic
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			c2p_dq <= '0;
			c2p_mask <= '0;
			c2p_wren <= '0;
		end else begin
			c2p_dq <= phy_ddio_dq;
			c2p_mask <= phy_ddio_wrdata_mask;
			c2p_wren <= phy_ddio_wrdata_en;
		end
	end

	// Only phase 0 of the full-rate read enable drives the VFIFO valid path
	// In half rate both phases carry the same request
	generate
		if (extra_vfifo_shift > 0) begin : g_extra_shift
			logic [extra_vfifo_shift-1:0] shift_q;

			// Stage 0 takes the new request, the last stage feeds the lanes
			always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
				if (!reset_n_afi_clk) begin
					shift_q <= '0;
				end else begin
					shift_q[0] <= afi_rdata_en_full[0];
					for (int i = 1; i < extra_vfifo_shift; i++) begin
						shift_q[i] <= shift_q[i-1];
					end
				end
			end

			assign rdata_en_full_shifted = shift_q[extra_vfifo_shift-1];
		end else begin : g_no_shift
			// No extra shift, the read enable goes straight to the lanes
			assign rdata_en_full_shifted = afi_rdata_en_full[0];
		end
	endgenerate

endmodule

// File: ddr_io_pkg.sv
package ddr_io_pkg;

	// Geometry of the data path
	localparam int num_dqs_groups = 2;
	localparam int dq_per_group = 8;

	// Half rate, so one AFI cycle carries two memory clocks
	localparam int afi_rate_ratio = 2;

	// Two DDR beats per memory clock
	localparam int num_slots = 2 * afi_rate_ratio;

	// One group's data across all time slots of an AFI cycle
	localparam int group_dq_width = num_slots * dq_per_group;

	localparam int afi_data_width = num_slots * num_dqs_groups * dq_per_group;

	// One mask bit per group and slot
	localparam int afi_mask_width = num_slots * num_dqs_groups;

	// One write-data enable per group and rate phase
	localparam int afi_wren_width = afi_rate_ratio * num_dqs_groups;

	// Extra cycles in front of the latency FIFO valid path, 0 gives a direct path
	localparam int extra_vfifo_shift = 1;

	localparam int read_latency_width = 5;

	// The delay line has one stage per nonzero latency value
	localparam int read_delay_depth = (2 ** read_latency_width) - 1;

	// AFI side buses, ordered by time slot and then by DQS group
	typedef logic [afi_data_width-1:0] afi_data_t;
	typedef logic [afi_mask_width-1:0] afi_mask_t;
	typedef logic [afi_wren_width-1:0] afi_wren_t;

	// Per-group slices, slot 0 in the low field
	typedef logic [group_dq_width-1:0] group_dq_t;
	typedef logic [num_slots-1:0] group_dm_t;
	typedef logic [afi_rate_ratio-1:0] group_oe_t;

	// Read latency count from the sequencer
	typedef logic [read_latency_width-1:0] read_latency_t;

	// One bit per rate phase
	typedef logic [afi_rate_ratio-1:0] rate_vec_t;

endpackage
